// File: verilog/cache_pkg.sv
package cache_pkg;

    localparam int num_lines = 16;
    localparam int index_w   = 4;
    localparam int tag_w     = 8;
    localparam int addr_w    = tag_w + index_w;
    localparam int data_w    = 32;

    typedef logic [addr_w-1:0]  addr_t;   // word address
    typedef logic [data_w-1:0]  word_t;
    typedef logic [index_w-1:0] index_t;
    typedef logic [tag_w-1:0]   tag_t;

    // tag sits in the upper bits of a word address
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } addr_split_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic  rd_wrt;   // 1 = read
        addr_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// File: verilog/line_ram.sv
`timescale 1ns/1ps

module line_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  cache_pkg::index_t waddr,
    input  entry_t            wdata,
    input  cache_pkg::index_t raddr_a,
    input  cache_pkg::index_t raddr_b,
    output entry_t            rdata_a,
    output entry_t            rdata_b
);

    entry_t mem [cache_pkg::num_lines];

    // cleared so every line comes up invalid and clean
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < cache_pkg::num_lines; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata_a = mem[raddr_a];   // request side
    assign rdata_b = mem[raddr_b];   // flush side

endmodule

// File: verilog/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable_cache,
    input  cache_pkg::cpu_req_t   req,
    input  logic                  fill,
    input  logic                  hit_access,
    input  logic                  wb_phase,
    input  cache_pkg::index_t     flush_index,
    input  logic                  one_line_flushed,
    input  logic                  flush_finish,
    input  logic                  done_mem,
    input  cache_pkg::word_t      mem_rdata,
    output logic                  miss_hit,
    output logic                  wrt_bck,
    output logic                  line_dirty,
    output logic                  rsp_valid,
    output cache_pkg::cpu_rsp_t   rsp,
    output cache_pkg::mem_req_t   mem_req,
    output logic                  tag_we,
    output cache_pkg::index_t     tag_waddr,
    output cache_pkg::tag_entry_t tag_wdata,
    output cache_pkg::index_t     tag_raddr_a,
    output cache_pkg::index_t     tag_raddr_b,
    input  cache_pkg::tag_entry_t tag_rdata_a,
    input  cache_pkg::tag_entry_t tag_rdata_b,
    output logic                  data_we,
    output cache_pkg::index_t     data_waddr,
    output cache_pkg::word_t      data_wdata,
    output cache_pkg::index_t     data_raddr_a,
    output cache_pkg::index_t     data_raddr_b,
    input  cache_pkg::word_t      data_rdata_a,
    input  cache_pkg::word_t      data_rdata_b
);

    cache_pkg::cpu_req_t    req_q;
    cache_pkg::tag_entry_t  victim_q;
    cache_pkg::word_t       victim_word_q;
    logic                   victim_pending;   // miss writeback still owed
    cache_pkg::addr_split_t cur;
    cache_pkg::addr_split_t held;
    logic                   line_clear;
    logic                   line_write;

    // live request in its strobe cycle, latched one afterwards
    assign cur  = enable_cache ? req.addr : req_q.addr;
    assign held = req_q.addr;

    assign tag_raddr_a  = cur.index;
    assign data_raddr_a = cur.index;
    assign tag_raddr_b  = flush_index;
    assign data_raddr_b = flush_index;

    assign miss_hit   = tag_rdata_a.valid && (tag_rdata_a.tag == cur.tag);
    assign wrt_bck    = victim_q.valid && victim_q.dirty;
    assign line_dirty = tag_rdata_b.valid && tag_rdata_b.dirty;

    always_ff @(posedge clk) begin
        if (enable_cache) begin
            req_q         <= req;
            victim_word_q <= data_rdata_a;   // survives the fill
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            victim_q       <= '0;
            victim_pending <= 1'b0;
        end else begin
            if (enable_cache) begin
                victim_q <= tag_rdata_a;
            end
            if (fill && wrt_bck) begin
                victim_pending <= 1'b1;
            end else if (victim_pending && done_mem) begin
                victim_pending <= 1'b0;
            end
        end
    end

    // flushed line keeps valid and tag, loses dirty
    assign line_clear = (one_line_flushed || flush_finish) && done_mem;
    assign line_write = fill || (hit_access && req_q.write);

    always_comb begin
        tag_we    = line_write;
        tag_waddr = held.index;
        tag_wdata = '{valid: 1'b1, dirty: req_q.write, tag: held.tag};
        if (line_clear) begin
            tag_we    = 1'b1;
            tag_waddr = flush_index;
            tag_wdata = '{valid: tag_rdata_b.valid, dirty: 1'b0, tag: tag_rdata_b.tag};
        end
    end

    assign data_we    = line_write;
    assign data_waddr = held.index;
    assign data_wdata = req_q.write ? req_q.wdata : mem_rdata;   // one word, write replaces it

    assign rsp_valid  = fill || hit_access;
    assign rsp.rdata  = fill ? mem_rdata : data_rdata_a;

    always_comb begin
        mem_req.rd_wrt = !wb_phase;
        mem_req.addr   = req_q.addr;
        mem_req.wdata  = data_rdata_b;
        if (victim_pending) begin
            mem_req.addr  = {victim_q.tag, held.index};
            mem_req.wdata = victim_word_q;
        end else if (wb_phase) begin
            mem_req.addr = {tag_rdata_b.tag, flush_index};   // flush writeback
        end
    end

    a_fill_not_hit: assert property (@(posedge clk) disable iff (!rst)
        !(fill && hit_access));

endmodule

// File: verilog/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              enable_cache,
    input  logic              line_dirty,
    input  logic              done_mem,
    input  logic              miss_hit,
    input  logic              wrt_bck,
    output logic              rd_wrt_mem,
    output logic              mem_enable,
    output logic              idle,
    output logic              mem_rdy,
    output logic              hit_access,
    output logic              wb_phase,
    output logic              one_line_flushed,
    output logic              flush_finish,
    output cache_pkg::index_t flush_index
);

    typedef enum logic [2:0] {
        IDLE,
        CACHE,
        MISS,
        WRITEBACK,
        FLUSH_START,
        FLUSH_IN_PROCESS
    } state_t;

    state_t            state;
    state_t            nxt_state;
    cache_pkg::index_t flush_cntr;
    logic              flush_clr;
    logic              flush_enable;
    logic              flush_end;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_cntr <= '0;
        end else if (flush_clr) begin
            flush_cntr <= '0;
        end else if (flush_enable) begin
            flush_cntr <= flush_cntr + 1'b1;
        end
    end

    assign flush_end   = (flush_cntr == cache_pkg::index_t'(cache_pkg::num_lines - 1));
    assign flush_index = flush_cntr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state        = state;
        rd_wrt_mem       = 1'b0;
        mem_enable       = 1'b0;
        idle             = 1'b0;
        mem_rdy          = 1'b0;
        hit_access       = 1'b0;
        wb_phase         = 1'b0;
        one_line_flushed = 1'b0;
        flush_finish     = 1'b0;
        flush_clr        = 1'b0;
        flush_enable     = 1'b0;
        case (state)
            IDLE: begin
                idle = 1'b1;
                if (flush) begin
                    nxt_state = FLUSH_START;
                    flush_clr = 1'b1;
                end else if (enable_cache && !miss_hit) begin
                    nxt_state = MISS;
                end else if (enable_cache) begin
                    nxt_state = CACHE;
                end
            end
            CACHE: begin
                hit_access = 1'b1;
                nxt_state  = IDLE;
            end
            MISS: begin
                mem_enable = 1'b1;   // read held until done
                rd_wrt_mem = 1'b1;
                if (done_mem) begin
                    mem_rdy   = 1'b1;
                    nxt_state = wrt_bck ? WRITEBACK : IDLE;
                end
            end
            WRITEBACK: begin
                mem_enable = 1'b1;
                wb_phase   = 1'b1;
                if (done_mem) begin
                    nxt_state = IDLE;
                end
            end
            FLUSH_START: begin
                if (line_dirty) begin
                    mem_enable = 1'b1;
                    wb_phase   = 1'b1;
                    nxt_state  = FLUSH_IN_PROCESS;
                end else if (flush_end) begin
                    // clean last line ends the walk too
                    flush_finish = 1'b1;
                    flush_clr    = 1'b1;
                    nxt_state    = IDLE;
                end else begin
                    flush_enable     = 1'b1;
                    one_line_flushed = 1'b1;
                end
            end
            FLUSH_IN_PROCESS: begin
                mem_enable = 1'b1;
                wb_phase   = 1'b1;
                if (done_mem && !flush_end) begin
                    flush_enable     = 1'b1;
                    one_line_flushed = 1'b1;
                    nxt_state        = FLUSH_START;
                end else if (done_mem) begin
                    flush_finish = 1'b1;
                    flush_clr    = 1'b1;
                    nxt_state    = IDLE;
                end
            end
            default: nxt_state = IDLE;
        endcase
    end

    // request stays up and the cache stays busy until memory answers
    a_mem_busy: assert property (@(posedge clk) disable iff (!rst)
        mem_enable && !done_mem |=> mem_enable && !idle);

    a_flush_last: assert property (@(posedge clk) disable iff (!rst)
        flush_finish |-> flush_end ##1 (idle && flush_index == '0));

    a_req_when_idle: assert property (@(posedge clk) disable iff (!rst)
        enable_cache |-> idle);

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable_cache,
    input  cache_pkg::cpu_req_t req,
    output logic                rsp_valid,
    output cache_pkg::cpu_rsp_t rsp,
    output logic                idle,
    input  logic                flush,
    output logic                flush_finish,
    output logic                mem_enable,
    output cache_pkg::mem_req_t mem_req,
    input  logic                done_mem,
    input  cache_pkg::word_t    mem_rdata
);

    logic                  miss_hit;
    logic                  wrt_bck;
    logic                  line_dirty;
    logic                  rd_wrt_mem;
    logic                  mem_rdy;
    logic                  hit_access;
    logic                  wb_phase;
    logic                  one_line_flushed;
    cache_pkg::index_t     flush_index;

    logic                  tag_we;
    cache_pkg::index_t     tag_waddr;
    cache_pkg::tag_entry_t tag_wdata;
    cache_pkg::index_t     tag_raddr_a;
    cache_pkg::index_t     tag_raddr_b;
    cache_pkg::tag_entry_t tag_rdata_a;
    cache_pkg::tag_entry_t tag_rdata_b;
    logic                  data_we;
    cache_pkg::index_t     data_waddr;
    cache_pkg::word_t      data_wdata;
    cache_pkg::index_t     data_raddr_a;
    cache_pkg::index_t     data_raddr_b;
    cache_pkg::word_t      data_rdata_a;
    cache_pkg::word_t      data_rdata_b;

    cache_controller u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .flush            (flush),
        .enable_cache     (enable_cache),
        .line_dirty       (line_dirty),
        .done_mem         (done_mem),
        .miss_hit         (miss_hit),
        .wrt_bck          (wrt_bck),
        .rd_wrt_mem       (rd_wrt_mem),
        .mem_enable       (mem_enable),
        .idle             (idle),
        .mem_rdy          (mem_rdy),
        .hit_access       (hit_access),
        .wb_phase         (wb_phase),
        .one_line_flushed (one_line_flushed),
        .flush_finish     (flush_finish),
        .flush_index      (flush_index)
    );

    cache_datapath u_dp (
        .clk              (clk),
        .rst              (rst),
        .enable_cache     (enable_cache),
        .req              (req),
        .fill             (mem_rdy),
        .hit_access       (hit_access),
        .wb_phase         (wb_phase),
        .flush_index      (flush_index),
        .one_line_flushed (one_line_flushed),
        .flush_finish     (flush_finish),
        .done_mem         (done_mem),
        .mem_rdata        (mem_rdata),
        .miss_hit         (miss_hit),
        .wrt_bck          (wrt_bck),
        .line_dirty       (line_dirty),
        .rsp_valid        (rsp_valid),
        .rsp              (rsp),
        .mem_req          (mem_req),
        .tag_we           (tag_we),
        .tag_waddr        (tag_waddr),
        .tag_wdata        (tag_wdata),
        .tag_raddr_a      (tag_raddr_a),
        .tag_raddr_b      (tag_raddr_b),
        .tag_rdata_a      (tag_rdata_a),
        .tag_rdata_b      (tag_rdata_b),
        .data_we          (data_we),
        .data_waddr       (data_waddr),
        .data_wdata       (data_wdata),
        .data_raddr_a     (data_raddr_a),
        .data_raddr_b     (data_raddr_b),
        .data_rdata_a     (data_rdata_a),
        .data_rdata_b     (data_rdata_b)
    );

    line_ram #(.entry_t(cache_pkg::tag_entry_t)) u_tag_ram (
        .clk     (clk),
        .rst     (rst),
        .we      (tag_we),
        .waddr   (tag_waddr),
        .wdata   (tag_wdata),
        .raddr_a (tag_raddr_a),
        .raddr_b (tag_raddr_b),
        .rdata_a (tag_rdata_a),
        .rdata_b (tag_rdata_b)
    );

    line_ram #(.entry_t(cache_pkg::word_t)) u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .we      (data_we),
        .waddr   (data_waddr),
        .wdata   (data_wdata),
        .raddr_a (data_raddr_a),
        .raddr_b (data_raddr_b),
        .rdata_a (data_rdata_a),
        .rdata_b (data_rdata_b)
    );

    // direction from the FSM must match what the datapath puts on the bus
    a_rd_wrt_agree: assert property (@(posedge clk) disable iff (!rst)
        mem_enable |-> (mem_req.rd_wrt == rd_wrt_mem));

endmodule

// File: sim/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable_cache,
    input  cache_pkg::cpu_req_t    req,
    input  logic                   flush,
    input  logic                   rsp_valid,
    input  cache_pkg::cpu_rsp_t    rsp,
    input  logic                   idle,
    input  logic                   flush_finish,
    input  logic                   mem_enable,
    input  cache_pkg::mem_req_t    mem_req,
    input  logic                   done_mem,
    input  logic                   check_en,
    input  logic [8*12-1:0]        test_name,
    input  logic [1:0]             test_kind,   // [1] flush, [0] write
    input  cache_pkg::word_t       exp_rdata,
    input  logic                   exp_hit,
    input  int                     exp_n_wb,
    input  cache_pkg::addr_t [0:2] exp_wb,
    output int                     pass_cnt,
    output int                     fail_cnt
);

    cache_pkg::word_t shadow [1 << cache_pkg::addr_w];   // last value the cpu wrote
    cache_pkg::addr_t wb_seen [$];
    cache_pkg::word_t got_rdata;
    int               cyc;
    int               start_cyc;
    int               rsp_cyc;
    int               n_rsp;
    int               n_ff;
    int               errs;
    bit               mem_used;
    bit               reset_checked;

    task automatic finish_test();
        if (test_kind[1]) begin
            if (n_ff != 1) begin
                $display("%0s: flush_finish pulsed %0d times instead of once", test_name, n_ff);
                errs++;
            end
            if (n_rsp != 0) begin
                $display("%0s: response strobe seen during a flush", test_name);
                errs++;
            end
        end else if (n_rsp != 1) begin
            $display("%0s: %0d responses instead of one", test_name, n_rsp);
            errs++;
        end else begin
            if (!test_kind[0] && got_rdata !== exp_rdata) begin
                $display("Error %0s: expected rdata %h, actual %h",
                         test_name, exp_rdata, got_rdata);
                errs++;
            end
            if (exp_hit && (mem_used || rsp_cyc != start_cyc + 1)) begin
                $display("%0s: hit used memory or answered late", test_name);
                errs++;
            end
            if (!exp_hit && !mem_used) begin
                $display("%0s: miss answered without a memory read", test_name);
                errs++;
            end
        end
        if (wb_seen.size() != exp_n_wb) begin
            $display("Error %0s: expected %0d writebacks, actual %0d",
                     test_name, exp_n_wb, wb_seen.size());
            errs++;
        end else begin
            for (int i = 0; i < exp_n_wb; i++) begin
                if (wb_seen[i] != exp_wb[i]) begin
                    $display("Error %0s: expected writeback address %h, actual %h",
                             test_name, exp_wb[i], wb_seen[i]);
                    errs++;
                end
            end
        end
        if (errs == 0) begin
            $display("test %0s: ok", test_name);
            pass_cnt++;
        end else begin
            $display("test %0s: %0d errors", test_name, errs);
            fail_cnt++;
        end
    endtask

    // outputs settle by mid cycle
    always @(negedge clk) begin
        if (rst) begin
            cyc++;
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!idle || mem_enable || rsp_valid || flush_finish) begin
                    $display("cache not idle and quiet after reset");
                    fail_cnt++;
                end
            end
            if (enable_cache || flush) begin
                start_cyc = cyc;
                n_rsp     = 0;
                n_ff      = 0;
                errs      = 0;
                mem_used  = 1'b0;
                wb_seen.delete();
                if (enable_cache && req.write) begin
                    shadow[req.addr] = req.wdata;
                end
            end
            if (mem_enable) begin
                mem_used = 1'b1;
            end
            if (rsp_valid) begin
                n_rsp++;
                rsp_cyc   = cyc;
                got_rdata = rsp.rdata;
            end
            if (flush_finish) begin
                n_ff++;
            end
            if (mem_enable && done_mem && !mem_req.rd_wrt) begin   // completed memory write
                wb_seen.push_back(mem_req.addr);
                if (mem_req.wdata !== shadow[mem_req.addr]) begin
                    $display("Error %0s: expected write data %h at %h, actual %h", test_name,
                             shadow[mem_req.addr], mem_req.addr, mem_req.wdata);
                    errs++;
                end
            end
            if (check_en) begin
                finish_test();
            end
        end
    end

endmodule

// File: sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    typedef struct packed {
        logic [8*12-1:0]        name;
        logic [1:0]             kind;   // 00 read, 01 write, 10 flush
        cache_pkg::addr_t       addr;
        cache_pkg::word_t       wdata;
        cache_pkg::word_t       exp_rdata;
        logic                   exp_hit;
        int                     n_wb;
        cache_pkg::addr_t [0:2] wb;
    } test_t;

    logic                clk;
    logic                rst;
    logic                enable_cache;
    cache_pkg::cpu_req_t req;
    logic                rsp_valid;
    cache_pkg::cpu_rsp_t rsp;
    logic                idle;
    logic                flush;
    logic                flush_finish;
    logic                mem_enable;
    cache_pkg::mem_req_t mem_req;
    logic                done_mem;
    cache_pkg::word_t    mem_rdata;

    test_t            tests [$];
    test_t            cur;
    logic             check_en;
    int               pass_cnt;
    int               fail_cnt;
    int               limit;
    int               cycle_cnt;
    cache_pkg::word_t mem_array [1 << cache_pkg::addr_w];
    logic [31:0]      rnd = 32'h01d8daae;
    int               wait_cnt;
    bit               busy;
    logic             done_next = 1'b0;
    cache_pkg::word_t rdata_next = '0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // address mixed into every word
    function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t a);
        return 32'hc3a5_6000 ^ {20'h0, a};
    endfunction

    function automatic void add_test(input logic [8*12-1:0] name, input logic [1:0] kind,
                                     input cache_pkg::addr_t addr, input cache_pkg::word_t wdata,
                                     input cache_pkg::word_t exp_rdata, input logic exp_hit,
                                     input int n_wb, input cache_pkg::addr_t [0:2] wb);
        test_t t;
        t = '{name, kind, addr, wdata, exp_rdata, exp_hit, n_wb, wb};
        tests.push_back(t);
    endfunction

    function automatic void build_table();
        add_test("rd_miss_a", 2'b00, 12'h013, '0, init_word(12'h013), 1'b0, 0, '0);
        add_test("rd_hit_a", 2'b00, 12'h013, '0, init_word(12'h013), 1'b1, 0, '0);
        add_test("wr_hit_a", 2'b01, 12'h013, 32'h1111_aaaa, '0, 1'b1, 0, '0);
        add_test("rd_after_wr", 2'b00, 12'h013, '0, 32'h1111_aaaa, 1'b1, 0, '0);
        add_test("rd_evict_a", 2'b00, 12'h023, '0, init_word(12'h023), 1'b0, 1,
                 {12'h013, 12'h0, 12'h0});
        add_test("rd_old_a", 2'b00, 12'h013, '0, 32'h1111_aaaa, 1'b0, 0, '0);
        add_test("wr_miss_b", 2'b01, 12'h105, 32'h2222_bbbb, '0, 1'b0, 0, '0);
        add_test("rd_b", 2'b00, 12'h105, '0, 32'h2222_bbbb, 1'b1, 0, '0);
        add_test("wr_miss_c", 2'b01, 12'h0af, 32'h3333_cccc, '0, 1'b0, 0, '0);
        add_test("wr_hit_a2", 2'b01, 12'h013, 32'h4444_dddd, '0, 1'b1, 0, '0);
        add_test("flush_dirty", 2'b10, '0, '0, '0, 1'b0, 3, {12'h013, 12'h105, 12'h0af});
        add_test("flush_clean", 2'b10, '0, '0, '0, 1'b0, 0, '0);
        add_test("rd_a_valid", 2'b00, 12'h013, '0, 32'h4444_dddd, 1'b1, 0, '0);
        add_test("rd_evict_c", 2'b00, 12'h1ff, '0, init_word(12'h1ff), 1'b0, 0, '0);
        add_test("rd_c_mem", 2'b00, 12'h0af, '0, 32'h3333_cccc, 1'b0, 0, '0);
        add_test("wr_hit_c", 2'b01, 12'h0af, 32'h5555_eeee, '0, 1'b1, 0, '0);
        add_test("wr_evict_c", 2'b01, 12'h2af, 32'h6666_ffff, '0, 1'b0, 1,
                 {12'h0af, 12'h0, 12'h0});
        add_test("rd_evict_c2", 2'b00, 12'h0af, '0, 32'h5555_eeee, 1'b0, 1,
                 {12'h2af, 12'h0, 12'h0});
    endfunction

    always #5 clk = ~clk;

    cache_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .enable_cache (enable_cache),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .idle         (idle),
        .flush        (flush),
        .flush_finish (flush_finish),
        .mem_enable   (mem_enable),
        .mem_req      (mem_req),
        .done_mem     (done_mem),
        .mem_rdata    (mem_rdata)
    );

    cache_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .enable_cache (enable_cache),
        .req          (req),
        .flush        (flush),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .idle         (idle),
        .flush_finish (flush_finish),
        .mem_enable   (mem_enable),
        .mem_req      (mem_req),
        .done_mem     (done_mem),
        .check_en     (check_en),
        .test_name    (cur.name),
        .test_kind    (cur.kind),
        .exp_rdata    (cur.exp_rdata),
        .exp_hit      (cur.exp_hit),
        .exp_n_wb     (cur.n_wb),
        .exp_wb       (cur.wb),
        .pass_cnt     (pass_cnt),
        .fail_cnt     (fail_cnt)
    );

    // memory model decides mid cycle, the DUT sees it after the next edge
    always @(negedge clk) begin
        if (rst) begin
            if (done_mem) begin
                if (!mem_req.rd_wrt) begin
                    mem_array[mem_req.addr] = mem_req.wdata;
                end
                busy      = 1'b0;
                done_next = 1'b0;
            end else if (busy || mem_enable) begin
                if (!busy) begin
                    busy     = 1'b1;
                    rnd      = xorshift32(rnd);
                    wait_cnt = int'(rnd % 32'd4);   // done after 1 to 4 cycles
                end else begin
                    wait_cnt--;
                end
                if (wait_cnt == 0) begin
                    done_next  = 1'b1;
                    rdata_next = mem_array[mem_req.addr];
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        done_mem  = done_next;
        mem_rdata = rdata_next;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (limit > 0 && cycle_cnt > limit) begin
            $display("timeout after %0d cycles with the cache still busy", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        enable_cache = 1'b0;
        req          = '0;
        flush        = 1'b0;
        done_mem     = 1'b0;
        mem_rdata    = '0;
        check_en     = 1'b0;
        cur          = '0;
        foreach (mem_array[a]) begin
            mem_array[a] = init_word(cache_pkg::addr_t'(a));
        end
        build_table();
        limit = tests.size() * cache_pkg::num_lines * 2 * 4 + 10;   // 4 is the worst memory delay
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
        foreach (tests[i]) begin
            @(posedge clk);
            #1;
            while (!idle) begin
                @(posedge clk);
                #1;
            end
            cur = tests[i];
            if (cur.kind[1]) begin
                flush = 1'b1;
            end else begin
                enable_cache = 1'b1;
                req          = '{write: cur.kind[0], addr: cur.addr, wdata: cur.wdata};
            end
            @(posedge clk);
            #1;
            enable_cache = 1'b0;
            flush        = 1'b0;
            while (!idle) begin
                @(posedge clk);
                #1;
            end
            check_en = 1'b1;
            @(posedge clk);
            #1;
            check_en = 1'b0;
        end
        @(posedge clk);
        #1;
        $display("%0d tests: %0d ok, %0d with errors", tests.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == tests.size()) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: cache_top.f
verilog/cache_pkg.sv
verilog/line_ram.sv
verilog/cache_datapath.sv
verilog/cache_controller.sv
verilog/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Test completed successfully

SRCS := $(wildcard verilog/*.sv sim/*.sv)
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
